//--- src/jpeg_coding_pkg.sv
package jpeg_coding_pkg;

    // signed coefficient, valid range -1024 to 1023
    typedef logic signed [15:0] coef_t;

    // position in zig-zag order
    typedef logic [5:0] coef_index_t;

    // magnitude category, 0 to 11
    typedef logic [3:0] category_t;

    // huffman symbol as run nibble over category nibble
    typedef logic [7:0] symbol_t;

    localparam coef_index_t LAST_INDEX = 6'd63;
    localparam symbol_t     SYM_ZRL    = 8'hf0;
    localparam symbol_t     SYM_EOB    = 8'h00;
    localparam logic [5:0]  ZRL_RUN    = 6'd16;

    // amplitude bits with their category, category 0 means a zero value
    typedef struct packed {
        logic [15:0] amplitude;
        category_t   category;
    } coded_coef_t;

    // code length is stored minus one, a code is never empty
    typedef struct packed {
        logic [15:0] code;
        logic [3:0]  len_m1;
    } code_entry_t;

endpackage

//--- src/huff_bus_pkg.sv
package huff_bus_pkg;

    // travels beside each coefficient through the pipeline
    typedef struct packed {
        jpeg_coding_pkg::coef_index_t index;
        logic                         valid;
    } stage_tag_t;

    // table load port, table_ac selects the AC table
    typedef struct packed {
        logic                         table_ac;
        logic [7:0]                   addr;
        jpeg_coding_pkg::code_entry_t entry;
    } table_write_t;

    // code in the low bits, amplitude bits above it
    typedef struct packed {
        logic [5:0]  length;
        logic [31:0] bits;
    } out_chunk_t;

endpackage

//--- src/coefficient_fetch.sv
`timescale 1ns/10ps

module coefficient_fetch (
    input  logic                         clock,
    input  logic                         nreset,
    input  logic                         start,
    input  logic                         rollback,
    input  jpeg_coding_pkg::coef_index_t resume_index,
    output jpeg_coding_pkg::coef_index_t fetch_addr,
    output huff_bus_pkg::stage_tag_t     tag
);

    import jpeg_coding_pkg::*;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_RUN
    } fetch_state_e;

    fetch_state_e state;
    coef_index_t  index;

    // memory is addressed straight from the counter
    assign fetch_addr = index;

    ////////////////////////////////////////////////////////////////////////////
    // address sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            state <= FETCH_IDLE;
            index <= '0;
            tag   <= '0;
        end else if (rollback) begin
            // the fetch issued this cycle is stale, restart from the run
            // may also wake the fetcher after it went idle at the block end
            state     <= FETCH_RUN;
            index     <= resume_index;
            tag.index <= index;
            tag.valid <= 1'b0;
        end else begin
            tag.index <= index;
            case (state)
                FETCH_IDLE: begin
                    tag.valid <= 1'b0;
                    if (start) begin
                        state <= FETCH_RUN;
                        index <= '0;
                    end
                end
                FETCH_RUN: begin
                    tag.valid <= 1'b1;
                    if (index == LAST_INDEX) begin
                        state <= FETCH_IDLE;
                    end else begin
                        index <= index + 6'd1;
                    end
                end
                default: begin
                    state     <= FETCH_IDLE;
                    tag.valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- src/coefficient_coder.sv
`timescale 1ns/10ps

module coefficient_coder (
    input  logic                         clock,
    input  logic                         nreset,
    input  logic                         rollback,
    input  jpeg_coding_pkg::coef_t       coef_data,
    input  huff_bus_pkg::stage_tag_t     tag_in,
    output huff_bus_pkg::stage_tag_t     tag_out,
    output jpeg_coding_pkg::coded_coef_t coded
);

    import jpeg_coding_pkg::*;

    localparam int CATEGORY_MAX = 11;

    coef_t       dc_pred;
    coef_t       value;
    logic [15:0] magnitude;
    logic [15:0] minus_one;
    logic [15:0] mask;
    category_t   category;
    logic        keep;

    // entry survives unless the run-length stage is rolling back
    assign keep = tag_in.valid && !rollback;

    always_comb begin
        // DC is coded as the difference to the previous block
        if (tag_in.index == '0) begin
            value = coef_data - dc_pred;
        end else begin
            value = coef_data;
        end

        magnitude = value[15] ? 16'(-value) : value;
        category  = '0;
        for (int i = 0; i < CATEGORY_MAX; i++) begin
            if (magnitude[i]) begin
                category = category_t'(i + 1);
            end
        end

        // negative values send the low bits of value minus one
        minus_one = value - 16'd1;
        mask      = (16'd1 << category) - 16'd1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            tag_out <= '0;
            dc_pred <= '0;
        end else begin
            tag_out.index <= tag_in.index;
            tag_out.valid <= keep;
            if (keep && tag_in.index == '0) begin
                dc_pred <= coef_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        coded.category  <= category;
        coded.amplitude <= value[15] ? (minus_one & mask) : value;
    end

endmodule

//--- src/run_length_coder.sv
`timescale 1ns/10ps

module run_length_coder (
    input  logic                         clock,
    input  logic                         nreset,
    input  huff_bus_pkg::stage_tag_t     tag_in,
    input  jpeg_coding_pkg::coded_coef_t coded_in,
    output logic                         table_ac,
    output jpeg_coding_pkg::symbol_t     table_addr,
    output logic                         rollback,
    output jpeg_coding_pkg::coef_index_t resume_index,
    output huff_bus_pkg::stage_tag_t     tag_out,
    output jpeg_coding_pkg::coded_coef_t coded_out,
    output logic                         emit
);

    import jpeg_coding_pkg::*;

    typedef enum logic [2:0] {
        SEL_DC,
        SEL_RUN,
        SEL_ZRL,
        SEL_EOB,
        SEL_SKIP
    } symbol_sel_e;

    symbol_sel_e sel;
    logic [5:0]  zero_count;
    logic        nonzero;

    ////////////////////////////////////////////////////////////////////////////
    // symbol selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nonzero      = coded_in.category != '0;
        // first position after sixteen zeros of the current run
        resume_index = tag_in.index + ZRL_RUN - zero_count;

        if (tag_in.index == '0) begin
            sel = SEL_DC;
        end else if (nonzero && zero_count >= ZRL_RUN) begin
            sel = SEL_ZRL;
        end else if (nonzero) begin
            sel = SEL_RUN;
        end else if (tag_in.index == LAST_INDEX) begin
            sel = SEL_EOB;
        end else begin
            sel = SEL_SKIP;
        end

        // ZRL is sent now and the nonzero coefficient comes round again
        rollback = tag_in.valid && sel == SEL_ZRL;
        table_ac = sel != SEL_DC;

        case (sel)
            SEL_DC:  table_addr = {4'h0, coded_in.category};
            SEL_ZRL: table_addr = SYM_ZRL;
            SEL_EOB: table_addr = SYM_EOB;
            default: table_addr = {zero_count[3:0], coded_in.category};
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // run counter and stage 3 register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            zero_count <= '0;
            emit       <= 1'b0;
            tag_out    <= '0;
        end else begin
            emit          <= tag_in.valid && sel != SEL_SKIP;
            tag_out.valid <= tag_in.valid;
            // a ZRL stands for the zeros up to the one before the resume point
            tag_out.index <= (sel == SEL_ZRL) ? resume_index - 6'd1 : tag_in.index;
            if (tag_in.valid) begin
                if (sel == SEL_SKIP || sel == SEL_EOB) begin
                    zero_count <= zero_count + 6'd1;
                end else begin
                    zero_count <= '0;
                end
            end
        end
    end

    // ZRL and EOB carry no amplitude bits
    always_ff @(posedge clock) begin
        if (sel == SEL_ZRL || sel == SEL_EOB) begin
            coded_out <= '0;
        end else begin
            coded_out <= coded_in;
        end
    end

endmodule

//--- src/huffman_table_ram.sv
`timescale 1ns/10ps

module huffman_table_ram (
    input  logic                         clock,
    input  logic                         wr_en,
    input  huff_bus_pkg::table_write_t   wr,
    input  logic                         rd_ac,
    input  jpeg_coding_pkg::symbol_t     rd_addr,
    output jpeg_coding_pkg::code_entry_t entry
);

    import jpeg_coding_pkg::*;

    localparam int DC_DEPTH = 16;
    localparam int AC_DEPTH = 256;

    // one entry per DC category
    code_entry_t dc_mem [DC_DEPTH];

    // one entry per run/category symbol
    code_entry_t ac_mem [AC_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // table load
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (wr_en) begin
            if (wr.table_ac) begin
                ac_mem[wr.addr] <= wr.entry;
            end else begin
                // DC symbols only use the category nibble
                dc_mem[wr.addr[3:0]] <= wr.entry;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    // registered read, the entry lines up with the next pipeline stage
    always_ff @(posedge clock) begin
        if (rd_ac) begin
            entry <= ac_mem[rd_addr];
        end else begin
            entry <= dc_mem[rd_addr[3:0]];
        end
    end

endmodule

//--- src/symbol_packer.sv
`timescale 1ns/10ps

module symbol_packer (
    input  logic                         clock,
    input  logic                         nreset,
    input  logic                         emit,
    input  huff_bus_pkg::stage_tag_t     tag,
    input  jpeg_coding_pkg::coded_coef_t coded,
    input  jpeg_coding_pkg::code_entry_t entry,
    output logic                         out_valid,
    output huff_bus_pkg::out_chunk_t     out_chunk,
    output logic                         block_done
);

    import jpeg_coding_pkg::*;

    logic [4:0]  code_len;
    logic [31:0] code_mask;
    logic [31:0] chunk_bits;
    logic [5:0]  chunk_len;

    always_comb begin
        code_len  = {1'b0, entry.len_m1} + 5'd1;
        code_mask = (32'd1 << code_len) - 32'd1;

        // huffman code at the bottom, amplitude bits right above it
        chunk_bits = ({16'h0, entry.code} & code_mask)
                   | ({16'h0, coded.amplitude} << code_len);
        chunk_len  = {1'b0, code_len} + {2'b00, coded.category};
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (nreset) begin
            out_valid  <= 1'b0;
            block_done <= 1'b0;
        end else begin
            out_valid  <= emit;
            // last position is only ever tagged on the final symbol
            block_done <= emit && tag.valid && tag.index == LAST_INDEX;
        end
    end

    always_ff @(posedge clock) begin
        if (emit) begin
            out_chunk.length <= chunk_len;
            out_chunk.bits   <= chunk_bits;
        end
    end

endmodule

//--- src/jpeg_huffman_encode.sv
`timescale 1ns/10ps

module jpeg_huffman_encode (
    input  logic                         clock,
    input  logic                         nreset,
    input  logic                         start,
    output jpeg_coding_pkg::coef_index_t fetch_addr,
    input  jpeg_coding_pkg::coef_t       coef_data,
    input  logic                         tbl_wr_en,
    input  huff_bus_pkg::table_write_t   tbl_wr,
    output logic                         out_valid,
    output huff_bus_pkg::out_chunk_t     out_chunk,
    output logic                         block_done
);

    import jpeg_coding_pkg::*;
    import huff_bus_pkg::*;

    // fetch to coder
    stage_tag_t  fetch_tag;

    // coder to run-length stage
    stage_tag_t  coder_tag;
    coded_coef_t coder_coded;

    // rollback path back up the pipeline
    logic        rollback;
    coef_index_t resume_index;

    // table lookup
    logic        table_ac;
    symbol_t     table_addr;
    code_entry_t table_entry;

    // run-length stage to packer
    logic        emit;
    stage_tag_t  pack_tag;
    coded_coef_t pack_coded;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////////////////////////////////////////

    coefficient_fetch u_fetch (
        .clock        (clock),
        .nreset       (nreset),
        .start        (start),
        .rollback     (rollback),
        .resume_index (resume_index),
        .fetch_addr   (fetch_addr),
        .tag          (fetch_tag)
    );

    coefficient_coder u_coder (
        .clock     (clock),
        .nreset    (nreset),
        .rollback  (rollback),
        .coef_data (coef_data),
        .tag_in    (fetch_tag),
        .tag_out   (coder_tag),
        .coded     (coder_coded)
    );

    run_length_coder u_rlc (
        .clock        (clock),
        .nreset       (nreset),
        .tag_in       (coder_tag),
        .coded_in     (coder_coded),
        .table_ac     (table_ac),
        .table_addr   (table_addr),
        .rollback     (rollback),
        .resume_index (resume_index),
        .tag_out      (pack_tag),
        .coded_out    (pack_coded),
        .emit         (emit)
    );

    huffman_table_ram u_table (
        .clock   (clock),
        .wr_en   (tbl_wr_en),
        .wr      (tbl_wr),
        .rd_ac   (table_ac),
        .rd_addr (table_addr),
        .entry   (table_entry)
    );

    symbol_packer u_packer (
        .clock      (clock),
        .nreset     (nreset),
        .emit       (emit),
        .tag        (pack_tag),
        .coded      (pack_coded),
        .entry      (table_entry),
        .out_valid  (out_valid),
        .out_chunk  (out_chunk),
        .block_done (block_done)
    );

endmodule

//--- test/jpeg_huffman_encode_assert.sv
`timescale 1ns/10ps

module jpeg_huffman_encode_assert (
    input logic                     clock,
    input logic                     nreset,
    input logic                     out_valid,
    input logic                     block_done,
    input huff_bus_pkg::out_chunk_t out_chunk
);

    // output strobes come out of reset clean
    assert property (@(posedge clock) disable iff (nreset)
        !$isunknown({out_valid, block_done}))
    else $error("output strobe is unknown after reset");

    // the block's last chunk carries block_done
    assert property (@(posedge clock) disable iff (nreset)
        block_done |-> out_valid)
    else $error("block_done raised without a chunk");

    // every chunk holds at least one code bit and fits the output word
    assert property (@(posedge clock) disable iff (nreset)
        out_valid |-> (out_chunk.length >= 6'd1 && out_chunk.length <= 6'd32))
    else $error("chunk length out of range");

endmodule

bind jpeg_huffman_encode jpeg_huffman_encode_assert u_assert (
    .clock      (clock),
    .nreset     (nreset),
    .out_valid  (out_valid),
    .block_done (block_done),
    .out_chunk  (out_chunk)
);

//--- test/jpeg_huffman_encode_tb.sv
`timescale 1ns/10ps

module jpeg_huffman_encode_tb;

    import jpeg_coding_pkg::*;
    import huff_bus_pkg::*;

    typedef bit bit_q_t[$];
    typedef coef_t block_t[64];

    localparam int BLOCK_TIMEOUT = 2000;

    logic         clock;
    logic         nreset;
    logic         start;
    coef_index_t  fetch_addr;
    coef_t        coef_data;
    logic         tbl_wr_en;
    table_write_t tbl_wr;
    logic         out_valid;
    out_chunk_t   out_chunk;
    logic         block_done;

    block_t      mem;
    block_t      blk;
    coef_t       prev_dc;
    bit_q_t      expected_q;
    bit_q_t      received_q;
    int          blocks_seen;
    int          error_count;
    string       test_name;
    logic [31:0] rng;
    int          code_of [2][256];
    int          len_of [2][256];

    int dc_counts [16] = '{0, 1, 5, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0};
    int ac_counts [16] = '{0, 2, 1, 3, 3, 2, 4, 3, 5, 5, 4, 4, 0, 0, 1, 'h7d};
    int dc_vals [162];
    int ac_vals [162] = '{
        'h01, 'h02, 'h03, 'h00, 'h04, 'h11, 'h05, 'h12, 'h21, 'h31, 'h41, 'h06, 'h13, 'h51,
        'h61, 'h07, 'h22, 'h71, 'h14, 'h32, 'h81, 'h91, 'ha1, 'h08, 'h23, 'h42, 'hb1, 'hc1,
        'h15, 'h52, 'hd1, 'hf0, 'h24, 'h33, 'h62, 'h72, 'h82, 'h09, 'h0a, 'h16, 'h17, 'h18,
        'h19, 'h1a, 'h25, 'h26, 'h27, 'h28, 'h29, 'h2a, 'h34, 'h35, 'h36, 'h37, 'h38, 'h39,
        'h3a, 'h43, 'h44, 'h45, 'h46, 'h47, 'h48, 'h49, 'h4a, 'h53, 'h54, 'h55, 'h56, 'h57,
        'h58, 'h59, 'h5a, 'h63, 'h64, 'h65, 'h66, 'h67, 'h68, 'h69, 'h6a, 'h73, 'h74, 'h75,
        'h76, 'h77, 'h78, 'h79, 'h7a, 'h83, 'h84, 'h85, 'h86, 'h87, 'h88, 'h89, 'h8a, 'h92,
        'h93, 'h94, 'h95, 'h96, 'h97, 'h98, 'h99, 'h9a, 'ha2, 'ha3, 'ha4, 'ha5, 'ha6, 'ha7,
        'ha8, 'ha9, 'haa, 'hb2, 'hb3, 'hb4, 'hb5, 'hb6, 'hb7, 'hb8, 'hb9, 'hba, 'hc2, 'hc3,
        'hc4, 'hc5, 'hc6, 'hc7, 'hc8, 'hc9, 'hca, 'hd2, 'hd3, 'hd4, 'hd5, 'hd6, 'hd7, 'hd8,
        'hd9, 'hda, 'he1, 'he2, 'he3, 'he4, 'he5, 'he6, 'he7, 'he8, 'he9, 'hea, 'hf1, 'hf2,
        'hf3, 'hf4, 'hf5, 'hf6, 'hf7, 'hf8, 'hf9, 'hfa
    };

    jpeg_huffman_encode u_dut (
        .clock      (clock),
        .nreset     (nreset),
        .start      (start),
        .fetch_addr (fetch_addr),
        .coef_data  (coef_data),
        .tbl_wr_en  (tbl_wr_en),
        .tbl_wr     (tbl_wr),
        .out_valid  (out_valid),
        .out_chunk  (out_chunk),
        .block_done (block_done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // block memory with one cycle of read latency
    always @(posedge clock) begin
        coef_data <= mem[fetch_addr];
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            stop_with_failure($sformatf("FAIL %s expected %0d actual %0d",
                                        name, expected, actual));
        end
    endtask

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int category_of(input int v);
        int mag;
        int cat;
        mag = (v < 0) ? -v : v;
        cat = 0;
        while (mag != 0) begin
            cat++;
            mag = mag >> 1;
        end
        return cat;
    endfunction

    function automatic void push_bits(inout bit_q_t q, input int value, input int count);
        for (int k = 0; k < count; k++) begin
            q.push_back(value[k]);
        end
    endfunction

    // symbol code followed by amplitude bits with each field LSB first
    function automatic void push_symbol(inout bit_q_t q, input int ac, input int sym,
                                        input int v, input int cat);
        int amp;
        amp = (v < 0) ? (v + (1 << cat) - 1) : v;
        push_bits(q, code_of[ac][sym], len_of[ac][sym]);
        push_bits(q, amp, cat);
    endfunction

    function automatic bit_q_t reference_bits(input block_t b, input coef_t dc_before);
        bit_q_t q;
        int     diff;
        int     cat;
        int     run;
        diff = int'(b[0]) - int'(dc_before);
        push_symbol(q, 0, category_of(diff), diff, category_of(diff));
        run = 0;
        for (int i = 1; i < 64; i++) begin
            if (b[i] == 0) begin
                run++;
            end else begin
                while (run >= 16) begin
                    push_symbol(q, 1, 'hf0, 0, 0);
                    run -= 16;
                end
                cat = category_of(b[i]);
                push_symbol(q, 1, run * 16 + cat, b[i], cat);
                run = 0;
            end
        end
        if (b[63] == 0) begin
            push_symbol(q, 1, 'h00, 0, 0);
        end
        return q;
    endfunction

    // build canonical codes from counts per length and write them into the DUT table
    task automatic load_table(input int ac, input int counts[16], input int vals[162]);
        int code;
        int k;
        code = 0;
        k    = 0;
        for (int len = 1; len <= 16; len++) begin
            for (int j = 0; j < counts[len-1]; j++) begin
                code_of[ac][vals[k]] = code;
                len_of[ac][vals[k]]  = len;
                tbl_wr_en = 1'b1;
                tbl_wr    = '{table_ac: ac[0], addr: 8'(vals[k]),
                              entry: '{code: 16'(code), len_m1: 4'(len - 1)}};
                tick();
                code++;
                k++;
            end
            code = code << 1;
        end
        tbl_wr_en = 1'b0;
    endtask

    task automatic apply_reset();
        nreset = 1'b1;
        repeat (2) tick();
        nreset  = 1'b0;
        prev_dc = '0;
    endtask

    task automatic run_block(input string name);
        int seen;
        int cycles;
        test_name  = name;
        expected_q = reference_bits(blk, prev_dc);
        prev_dc    = blk[0];
        mem        = blk;
        seen       = blocks_seen;
        start      = 1'b1;
        tick();
        start  = 1'b0;
        // the block is read from the top in the cycle after start
        check_value({name, " first fetch"}, 0, int'(fetch_addr));
        cycles = 0;
        while (blocks_seen == seen) begin
            if (cycles == BLOCK_TIMEOUT) begin
                stop_with_failure($sformatf("no block_done for %s", name));
            end
            tick();
            cycles++;
        end
        repeat (2) tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(posedge clock);
            if (!nreset && out_valid) begin
                check_value({test_name, " upper bits"}, 0,
                            int'(out_chunk.bits >> out_chunk.length));
                for (int k = 0; k < int'(out_chunk.length); k++) begin
                    received_q.push_back(out_chunk.bits[k]);
                end
                if (block_done) begin
                    check_value({test_name, " length"}, expected_q.size(), received_q.size());
                    for (int k = 0; k < expected_q.size(); k++) begin
                        check_value($sformatf("%s bit %0d", test_name, k),
                                    expected_q[k], received_q[k]);
                    end
                    received_q.delete();
                    blocks_seen++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        nreset      = 1'b1;
        start       = 1'b0;
        coef_data   = '0;
        tbl_wr_en   = 1'b0;
        tbl_wr      = '0;
        blocks_seen = 0;
        error_count = 0;
        rng         = 32'd45813;
        test_name   = "reset";
        for (int i = 0; i < 162; i++) begin
            dc_vals[i] = (i < 12) ? i : 0;
        end
        blk = '{default: '0};
        mem = blk;
        apply_reset();
        load_table(0, dc_counts, dc_vals);
        load_table(1, ac_counts, ac_vals);

        blk[0] = 16'sd5;
        run_block("dc_only");

        apply_reset();
        run_block("dc_chain_5");
        blk[0] = -16'sd3;
        run_block("dc_chain_m3");
        blk[0] = 16'sd1020;
        run_block("dc_chain_1020");

        blk     = '{default: '0};
        blk[0]  = 16'sd7;
        blk[21] = 16'sd3;
        blk[62] = -16'sd2;
        run_block("zero_runs");

        blk     = '{default: '0};
        blk[0]  = 16'sd2;
        blk[63] = -16'sd100;
        run_block("last_nonzero");

        for (int n = 0; n < 20; n++) begin
            rng    = xorshift(rng);
            blk[0] = coef_t'(int'(rng % 2048) - 1024);
            for (int i = 1; i < 64; i++) begin
                rng    = xorshift(rng);
                blk[i] = '0;
                if (rng[1:0] == 2'b00) begin
                    rng    = xorshift(rng);
                    blk[i] = coef_t'(int'(rng % 2047) - 1023);
                end
            end
            run_block($sformatf("random_%0d", n));
        end

        // DC prediction starts again from zero
        apply_reset();
        blk = '{default: '0};
        blk[0] = -16'sd40;
        run_block("dc_after_reset");

        if (error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

//--- jpeg_huffman.f
src/jpeg_coding_pkg.sv
src/huff_bus_pkg.sv
src/coefficient_fetch.sv
src/coefficient_coder.sv
src/run_length_coder.sv
src/huffman_table_ram.sv
src/symbol_packer.sv
src/jpeg_huffman_encode.sv
test/jpeg_huffman_encode_assert.sv
test/jpeg_huffman_encode_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the JPEG Huffman encoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        -f jpeg_huffman.f \
        --top-module jpeg_huffman_encode_tb \
        -o sim_jpeg_huffman; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_jpeg_huffman > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
